// File: include/lsu_defines.svh
// lane extension macros for load results, included by the align unit
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// lane widths in bits
`define LSU_LANE_B 8
`define LSU_LANE_H 16
`define LSU_LANE_W 32

// v must be a plain signal name, result is always 64 bits
`define LSU_SEXT(v, w) {{(64 - (w)){v[(w) - 1]}}, v[(w) - 1:0]}

`define LSU_ZEXT(v, w) {{(64 - (w)){1'b0}}, v[(w) - 1:0]}

`endif

// File: source/lsu_pkg.sv
// pipeline-side types and register map, imported by the lsu stage modules
package lsu_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;

  // access size, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    BYTE,
    HALF,
    WORD,
    DWORD
  } mem_size_e;

  typedef struct packed {
    logic      write;
    xlen_t     addr;
    xlen_t     wdata;
    mem_size_e size;
    logic      sext;   // sign-extend loads
  } lsu_req_t;

  typedef struct packed {
    xlen_t rdata;
    logic  err;   // disabled or misaligned
  } lsu_rsp_t;

  localparam int CFG_AW = 2;

  typedef logic [CFG_AW-1:0] cfg_addr_t;

  localparam cfg_addr_t CFG_CTRL       = 2'd0;
  localparam cfg_addr_t CFG_FAULT_CNT  = 2'd1;
  localparam cfg_addr_t CFG_FAULT_ADDR = 2'd2;

endpackage

// File: source/bus_pkg.sv
// memory-bus types shared by the controller, align unit and data RAM
package bus_pkg;

  localparam int BUS_AW    = 64;
  localparam int BUS_DW    = 64;
  localparam int BUS_SW    = BUS_DW / 8;
  localparam int BYTE_OFFS = $clog2(BUS_SW);

  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  typedef logic [BUS_AW-1:0] baddr_t;   // byte address
  typedef logic [BUS_DW-1:0] bdata_t;
  typedef logic [BUS_SW-1:0] bstrb_t;

  typedef struct packed {
    baddr_t addr;
    bdata_t data;
    bstrb_t strb;
  } bus_wr_t;

  typedef struct packed {
    baddr_t addr;
  } bus_rd_req_t;

endpackage

// File: source/lsu_align.sv
// lane alignment for stores and extraction with extension for loads, purely combinational
`timescale 1ns/100ps

`include "lsu_defines.svh"

module lsu_align
  import lsu_pkg::*;
  import bus_pkg::*;
(
  input  lsu_req_t req_i,
  input  bdata_t   rdata_i,
  output bus_wr_t  wr_o,
  output logic     misaligned_o,
  output xlen_t    load_o
);

  logic [BYTE_OFFS-1:0] offs;
  bstrb_t               size_mask;
  bdata_t               shifted;

  assign offs = req_i.addr[BYTE_OFFS-1:0];

  always_comb begin
    case (req_i.size)
      BYTE:    size_mask = 8'h01;
      HALF:    size_mask = 8'h03;
      WORD:    size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  // low address bits must be a multiple of the size
  always_comb begin
    case (req_i.size)
      BYTE:    misaligned_o = 1'b0;
      HALF:    misaligned_o = offs[0];
      WORD:    misaligned_o = |offs[1:0];
      default: misaligned_o = |offs;
    endcase
  end

  assign wr_o.addr = req_i.addr & ~baddr_t'(BUS_SW - 1);   // word address for both channels
  assign wr_o.data = req_i.wdata << {offs, 3'b000};
  assign wr_o.strb = size_mask << offs;

  assign shifted = rdata_i >> {offs, 3'b000};

  always_comb begin
    case (req_i.size)
      BYTE: begin
        load_o = req_i.sext ? `LSU_SEXT(shifted, `LSU_LANE_B) : `LSU_ZEXT(shifted, `LSU_LANE_B);
      end
      HALF: begin
        load_o = req_i.sext ? `LSU_SEXT(shifted, `LSU_LANE_H) : `LSU_ZEXT(shifted, `LSU_LANE_H);
      end
      WORD: begin
        load_o = req_i.sext ? `LSU_SEXT(shifted, `LSU_LANE_W) : `LSU_ZEXT(shifted, `LSU_LANE_W);
      end
      default: begin
        load_o = shifted;   // full dword, nothing to extend
      end
    endcase
  end

endmodule

// File: source/lsu_ctrl.sv
// request FSM of the memory stage, checks for faults and runs one bus transaction per request
`timescale 1ns/100ps

module lsu_ctrl
  import lsu_pkg::*;
  import bus_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        req_valid_i,
  input  lsu_req_t    req_i,
  output logic        req_ready_o,
  output logic        rsp_valid_o,
  output lsu_rsp_t    rsp_o,
  input  logic        rsp_ready_i,
  input  logic        enable_i,
  output logic        fault_o,
  output xlen_t       fault_addr_o,
  output lsu_req_t    cur_req_o,
  input  logic        misaligned_i,
  input  bus_wr_t     wr_i,
  input  xlen_t       load_data_i,
  output logic        wr_valid_o,
  output bus_wr_t     wr_o,
  input  logic        wr_ready_i,
  input  logic        ack_valid_i,
  output logic        ack_ready_o,
  output logic        rd_valid_o,
  output bus_rd_req_t rd_o,
  input  logic        rd_ready_i,
  input  logic        rdata_valid_i,
  input  bdata_t      rdata_i,
  output logic        rdata_ready_o,
  output bdata_t      raw_rdata_o
);

  typedef enum logic [2:0] {IDLE, WR_REQ, WR_ACK, RD_REQ, RD_DATA, RESP} state_e;

  state_e   state_q, state_d;
  lsu_req_t req_q;
  lsu_rsp_t rsp_q;
  logic     fault_q;
  logic     req_fire;
  logic     fault_now;

  assign req_fire  = req_valid_i && req_ready_o;
  assign fault_now = !enable_i || misaligned_i;

  // in IDLE the align unit checks the incoming request so a fault is known at transfer
  assign cur_req_o = (state_q == IDLE) ? req_i : req_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          if (fault_now) state_d = RESP;
          else if (req_i.write) state_d = WR_REQ;
          else state_d = RD_REQ;
        end
      end
      WR_REQ:  if (wr_ready_i) state_d = WR_ACK;
      WR_ACK:  if (ack_valid_i) state_d = RESP;
      RD_REQ:  if (rd_ready_i) state_d = RD_DATA;
      RD_DATA: if (rdata_valid_i) state_d = RESP;
      RESP:    if (rsp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      fault_q <= 1'b0;
    end else begin
      state_q <= state_d;
      fault_q <= req_fire && fault_now;   // one-cycle pulse to the register block
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_q       <= req_i;
      rsp_q.rdata <= '0;
      rsp_q.err   <= fault_now;
    end else if (state_q == RD_DATA && rdata_valid_i) begin
      rsp_q.rdata <= load_data_i;
    end
  end

  assign req_ready_o   = (state_q == IDLE);
  assign rsp_valid_o   = (state_q == RESP);
  assign rsp_o         = rsp_q;
  assign fault_o       = fault_q;
  assign fault_addr_o  = req_q.addr;
  assign wr_valid_o    = (state_q == WR_REQ);
  assign wr_o          = wr_i;
  assign ack_ready_o   = (state_q == WR_ACK);
  assign rd_valid_o    = (state_q == RD_REQ);
  assign rd_o.addr     = wr_i.addr;   // same word address as a store
  assign rdata_ready_o = (state_q == RD_DATA);
  assign raw_rdata_o   = rdata_i;

endmodule

// File: source/lsu_cfg.sv
// control and status registers of the memory stage, written and read over a simple register port
`timescale 1ns/100ps

module lsu_cfg
  import lsu_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n_i,
  input  logic      cfg_we_i,
  input  cfg_addr_t cfg_addr_i,
  input  xlen_t     cfg_wdata_i,
  output xlen_t     cfg_rdata_o,
  input  logic      fault_i,
  input  xlen_t     fault_addr_i,
  output logic      enable_o
);

  logic  enable_q;
  xlen_t fault_cnt_q;
  xlen_t fault_addr_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q     <= 1'b1;
      fault_cnt_q  <= '0;
      fault_addr_q <= '0;
    end else begin
      if (cfg_we_i && cfg_addr_i == CFG_CTRL) enable_q <= cfg_wdata_i[0];

      // any write clears the counter, it wins over a fault in the same cycle
      if (cfg_we_i && cfg_addr_i == CFG_FAULT_CNT) begin
        fault_cnt_q <= '0;
      end else if (fault_i && !(&fault_cnt_q)) begin
        fault_cnt_q <= fault_cnt_q + 1'b1;   // saturates at all ones
      end

      if (fault_i) fault_addr_q <= fault_addr_i;
    end
  end

  always_comb begin
    case (cfg_addr_i)
      CFG_CTRL:       cfg_rdata_o = xlen_t'(enable_q);
      CFG_FAULT_CNT:  cfg_rdata_o = fault_cnt_q;
      CFG_FAULT_ADDR: cfg_rdata_o = fault_addr_q;
      default:        cfg_rdata_o = '0;
    endcase
  end

  assign enable_o = enable_q;

endmodule

// File: source/data_ram.sv
// synchronous data RAM slave on the lsu bus, fixed one-cycle accept and one-cycle answer
`timescale 1ns/100ps

module data_ram
  import bus_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        wr_valid_i,
  input  bus_wr_t     wr_i,
  output logic        wr_ready_o,
  output logic        ack_valid_o,
  input  logic        ack_ready_i,
  input  logic        rd_valid_i,
  input  bus_rd_req_t rd_i,
  output logic        rd_ready_o,
  output logic        rdata_valid_o,
  output bdata_t      rdata_o,
  input  logic        rdata_ready_i
);

  bdata_t            mem [RAM_WORDS];
  logic [RAM_AW-1:0] wr_idx;
  logic [RAM_AW-1:0] rd_idx;

  assign wr_idx = wr_i.addr[BYTE_OFFS +: RAM_AW];
  assign rd_idx = rd_i.addr[BYTE_OFFS +: RAM_AW];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ready_o    <= 1'b0;
      ack_valid_o   <= 1'b0;
      rd_ready_o    <= 1'b0;
      rdata_valid_o <= 1'b0;
    end else begin
      wr_ready_o <= wr_valid_i && !wr_ready_o;   // drops right after the transfer
      rd_ready_o <= rd_valid_i && !rd_ready_o;
      if (wr_valid_i && wr_ready_o) ack_valid_o <= 1'b1;
      else if (ack_ready_i) ack_valid_o <= 1'b0;
      if (rd_valid_i && rd_ready_o) rdata_valid_o <= 1'b1;
      else if (rdata_ready_i) rdata_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_valid_i && wr_ready_o) begin
      for (int b = 0; b < BUS_SW; b++) begin
        if (wr_i.strb[b]) mem[wr_idx][b*8 +: 8] <= wr_i.data[b*8 +: 8];
      end
    end
    if (rd_valid_i && rd_ready_o) rdata_o <= mem[rd_idx];   // held until taken
  end

endmodule

// File: source/lsu_top.sv
// top level of the memory-access stage, pipeline request and response in, register port beside
`timescale 1ns/100ps

module lsu_top
  import lsu_pkg::*;
  import bus_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n_i,
  input  logic      req_valid_i,
  input  lsu_req_t  req_i,
  output logic      req_ready_o,
  output logic      rsp_valid_o,
  output lsu_rsp_t  rsp_o,
  input  logic      rsp_ready_i,
  input  logic      cfg_we_i,
  input  cfg_addr_t cfg_addr_i,
  input  xlen_t     cfg_wdata_i,
  output xlen_t     cfg_rdata_o
);

  lsu_req_t    cur_req;
  bus_wr_t     wr_aligned, wr;
  bus_rd_req_t rd;
  bdata_t      rdata, raw_rdata;
  xlen_t       load_data, fault_addr;
  logic        misaligned, enable, fault;
  logic        wr_valid, wr_ready, ack_valid, ack_ready;
  logic        rd_valid, rd_ready, rdata_valid, rdata_ready;

  lsu_ctrl u_ctrl (
    .clk, .arst_n_i, .req_valid_i, .req_i, .req_ready_o, .rsp_valid_o, .rsp_o, .rsp_ready_i,
    .enable_i(enable), .fault_o(fault), .fault_addr_o(fault_addr), .cur_req_o(cur_req),
    .misaligned_i(misaligned), .wr_i(wr_aligned), .load_data_i(load_data),
    .wr_valid_o(wr_valid), .wr_o(wr), .wr_ready_i(wr_ready),
    .ack_valid_i(ack_valid), .ack_ready_o(ack_ready),
    .rd_valid_o(rd_valid), .rd_o(rd), .rd_ready_i(rd_ready),
    .rdata_valid_i(rdata_valid), .rdata_i(rdata), .rdata_ready_o(rdata_ready),
    .raw_rdata_o(raw_rdata)
  );

  lsu_align u_align (
    .req_i(cur_req), .rdata_i(raw_rdata), .wr_o(wr_aligned), .misaligned_o(misaligned),
    .load_o(load_data)
  );

  lsu_cfg u_cfg (
    .clk, .arst_n_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
    .fault_i(fault), .fault_addr_i(fault_addr), .enable_o(enable)
  );

  data_ram u_ram (
    .clk, .arst_n_i,
    .wr_valid_i(wr_valid), .wr_i(wr), .wr_ready_o(wr_ready),
    .ack_valid_o(ack_valid), .ack_ready_i(ack_ready),
    .rd_valid_i(rd_valid), .rd_i(rd), .rd_ready_o(rd_ready),
    .rdata_valid_o(rdata_valid), .rdata_o(rdata), .rdata_ready_i(rdata_ready)
  );

endmodule

// File: test/lsu_asserts.sv
// handshake assertions bound into the lsu controller, compiled together with the testbench
`timescale 1ns/100ps

module lsu_asserts
  import lsu_pkg::*;
(
  input logic     clk,
  input logic     arst_n_i,
  input logic     req_valid_i,
  input lsu_req_t req_i,
  input logic     req_ready_o,
  input logic     rsp_valid_o,
  input lsu_rsp_t rsp_o,
  input logic     rsp_ready_i,
  input logic     wr_valid_o,
  input logic     wr_ready_i,
  input logic     rd_valid_o,
  input logic     rd_ready_i
);

  int   fail_cnt = 0;   // polled by the testbench at the end
  logic in_flight;      // taken but its response not yet transferred

  task automatic flag(input string what);
    $error("%s", what);
    fail_cnt++;
  endtask

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_flight <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      in_flight <= 1'b1;
    end else if (rsp_valid_o && rsp_ready_i) begin
      in_flight <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n_i)
    req_valid_i && !req_ready_o |=> $stable(req_i))
    else flag("request payload changed while waiting for ready");

  assert property (@(posedge clk) disable iff (!arst_n_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else flag("response dropped or changed under back-pressure");

  assert property (@(posedge clk) disable iff (!arst_n_i)
    wr_valid_o && !wr_ready_i |=> wr_valid_o)
    else flag("write valid dropped before ready");

  assert property (@(posedge clk) disable iff (!arst_n_i)
    rd_valid_o && !rd_ready_i |=> rd_valid_o)
    else flag("read valid dropped before ready");

  // one request in flight, ready again only once its response is gone
  assert property (@(posedge clk) disable iff (!arst_n_i) req_ready_o == !in_flight)
    else flag("request ready does not follow the request in flight");

  assert property (@(posedge clk) disable iff (!arst_n_i) rsp_valid_o |-> in_flight)
    else flag("response valid without a request in flight");

endmodule

bind lsu_ctrl lsu_asserts u_asserts (.*);

// File: test/tb_lsu.sv
// directed testbench for the memory-access stage, top module of the simulation
`timescale 1ns/100ps

module tb_lsu
  import lsu_pkg::*;
  import bus_pkg::*;
();

  localparam int TIMEOUT = 50;   // cycles per wait

  logic        clk;
  logic        arst_n;
  logic        req_valid, req_ready, rsp_valid, rsp_ready, cfg_we;
  lsu_req_t    req;
  lsu_rsp_t    rsp;
  cfg_addr_t   cfg_addr;
  xlen_t       cfg_wdata, cfg_rdata;
  logic [31:0] seed = 32'h453033b5;
  xlen_t       shadow [RAM_WORDS];   // model of the data RAM

  lsu_top u_dut (
    .clk, .arst_n_i(arst_n), .req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
    .rsp_valid_o(rsp_valid), .rsp_o(rsp), .rsp_ready_i(rsp_ready),
    .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata), .cfg_rdata_o(cfg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic guard(inout int t, input string what);
    t++;
    if (t > TIMEOUT) begin
      $display("Timed out: %s", what);
      stop_run();
    end
  endtask

  function automatic logic [31:0] xorshift32();
    seed ^= seed << 13;
    seed ^= seed >> 17;
    seed ^= seed << 5;
    return seed;
  endfunction

  function automatic xlen_t rand64();
    logic [31:0] hi;
    hi = xorshift32();
    return {hi, xorshift32()};
  endfunction

  // expected load result from a stored word, by offset, size and sign flag
  function automatic xlen_t expect_load(xlen_t word, int off, mem_size_e size, logic sext);
    int    w;
    xlen_t v;
    w = 8 << int'(size);
    v = word >> (off * 8);
    if (w == 64) return v;
    v = v & ((64'd1 << w) - 1);
    if (sext && v[w-1]) v = v | ~((64'd1 << w) - 1);
    return v;
  endfunction

  function automatic void shadow_store(xlen_t addr, xlen_t data, mem_size_e size);
    for (int b = 0; b < (1 << int'(size)); b++) begin
      shadow[addr[3 +: 8]][(addr[2:0] + b) * 8 +: 8] = data[b*8 +: 8];
    end
  endfunction

  // one request, response held back for hold cycles, lat counts edges to rsp_valid_o
  task automatic access(input logic wr, input xlen_t addr, input xlen_t data,
                        input mem_size_e size, input logic sext, input int hold,
                        output lsu_rsp_t got, output int lat);
    int       t;
    lsu_rsp_t first;
    t = 0;
    lat = 0;
    req_valid <= 1'b1;
    req       <= '{write: wr, addr: addr, wdata: data, size: size, sext: sext};
    rsp_ready <= (hold == 0);
    do begin
      @(posedge clk);
      guard(t, "request was never accepted");
    end while (!req_ready);
    req_valid <= 1'b0;
    do begin
      @(posedge clk);
      guard(lat, "no response after the request was accepted");
    end while (!rsp_valid);
    first = rsp;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      check("rsp_valid_o", rsp_valid, 1'b1);
      check("rsp_o", rsp, first);
      check("req_ready_o", req_ready, 1'b0);
    end
    if (hold > 0) begin
      rsp_ready <= 1'b1;
      @(posedge clk);
      check("rsp_valid_o", rsp_valid, 1'b1);   // transfers on this edge
    end
    got = first;
  endtask

  task automatic store(input xlen_t addr, input xlen_t data, input mem_size_e size);
    lsu_rsp_t r;
    int       lat;
    access(1'b1, addr, data, size, 1'b0, 0, r, lat);
    check("rsp_o.err", r.err, 1'b0);
    shadow_store(addr, data, size);
  endtask

  task automatic load_check(input xlen_t addr, input mem_size_e size, input logic sext);
    lsu_rsp_t r;
    int       lat;
    access(1'b0, addr, '0, size, sext, 0, r, lat);
    check("rsp_o.err", r.err, 1'b0);
    check("rsp_o.rdata", r.rdata, expect_load(shadow[addr[3 +: 8]], addr[2:0], size, sext));
  endtask

  task automatic cfg_write(input cfg_addr_t a, input xlen_t d);
    cfg_we    <= 1'b1;
    cfg_addr  <= a;
    cfg_wdata <= d;
    @(posedge clk);
    cfg_we <= 1'b0;
  endtask

  task automatic cfg_read(input cfg_addr_t a, output xlen_t d);
    cfg_addr <= a;
    @(posedge clk);
    d = cfg_rdata;
  endtask

  // faulting request, no bus traffic, counter and last address follow
  task automatic fault_check(input logic wr, input xlen_t addr, input mem_size_e size);
    lsu_rsp_t r;
    int       lat;
    xlen_t    cnt0, cnt1, faddr;
    cfg_read(CFG_FAULT_CNT, cnt0);
    access(wr, addr, rand64(), size, 1'b0, 0, r, lat);
    check("rsp_o.err", r.err, 1'b1);
    check("fault latency", lat, 1);
    cfg_read(CFG_FAULT_CNT, cnt1);
    check("CFG_FAULT_CNT", cnt1, cnt0 + 1);
    cfg_read(CFG_FAULT_ADDR, faddr);
    check("CFG_FAULT_ADDR", faddr, addr);
  endtask

  task automatic test_dword();
    xlen_t addr [8];
    for (int i = 0; i < 8; i++) begin
      addr[i] = xlen_t'(xorshift32() & 32'h7f8);
      store(addr[i], rand64(), DWORD);
    end
    for (int i = 0; i < 8; i++) load_check(addr[i], DWORD, 1'b0);
  endtask

  task automatic test_lanes();
    xlen_t     base;
    mem_size_e sz;
    base = 64'h100;
    store(base, rand64(), DWORD);
    for (int s = 0; s < 3; s++) begin
      sz = mem_size_e'(s);
      for (int off = 0; off < 8; off += (1 << s)) begin
        store(base + off, rand64(), sz);
        load_check(base + off, sz, 1'b0);
        load_check(base + off, sz, 1'b1);
        load_check(base, DWORD, 1'b0);   // neighbours untouched
      end
    end
  endtask

  task automatic test_misaligned();
    store(64'h200, rand64(), DWORD);
    fault_check(1'b1, 64'h201, HALF);
    fault_check(1'b0, 64'h202, WORD);
    fault_check(1'b1, 64'h204, DWORD);
    load_check(64'h200, DWORD, 1'b0);
  endtask

  task automatic test_disable();
    xlen_t v;
    cfg_write(CFG_CTRL, 64'd0);
    cfg_read(CFG_CTRL, v);
    check("CFG_CTRL", v, 64'd0);
    fault_check(1'b0, 64'h200, DWORD);
    cfg_write(CFG_CTRL, 64'd1);
    load_check(64'h200, DWORD, 1'b0);
    cfg_write(CFG_FAULT_CNT, 64'hff);   // any value clears
    cfg_read(CFG_FAULT_CNT, v);
    check("CFG_FAULT_CNT", v, 64'd0);
  endtask

  task automatic test_backpressure();
    lsu_rsp_t r;
    int       lat;
    xlen_t    addr;
    for (int i = 0; i < 4; i++) begin
      addr = xlen_t'(xorshift32() & 32'h7f8);
      store(addr, rand64(), DWORD);
      access(1'b0, addr, '0, DWORD, 1'b0, 1 + int'(xorshift32() % 6), r, lat);
      check("rsp_o.err", r.err, 1'b0);
      check("rsp_o.rdata", r.rdata, shadow[addr[3 +: 8]]);
    end
  endtask

  initial begin
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b1;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    check("req_ready_o", req_ready, 1'b1);
    check("rsp_valid_o", rsp_valid, 1'b0);
    test_dword();
    test_lanes();
    test_misaligned();
    test_disable();
    test_backpressure();
    @(posedge clk);
    if (u_dut.u_ctrl.u_asserts.fail_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("A bound assertion failed during the run");
      stop_run();
    end
  end

endmodule

// File: compile.f
+incdir+include
source/lsu_pkg.sv
source/bus_pkg.sv
source/lsu_align.sv
source/lsu_ctrl.sv
source/lsu_cfg.sv
source/data_ram.sv
source/lsu_top.sv
test/lsu_asserts.sv
test/tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - include
    files:
      - source/lsu_pkg.sv
      - source/bus_pkg.sv
      - source/lsu_align.sv
      - source/lsu_ctrl.sv
      - source/lsu_cfg.sv
      - source/data_ram.sv
      - source/lsu_top.sv
      - target: test
        files:
          - test/lsu_asserts.sv
          - test/tb_lsu.sv
